/* hdl/tier_host_params.svh */
//==========================================================================
// Build-time constants for the tier host block: register map, stack size,
// response timing and the tier ranges hosted by each core.
//==========================================================================
`ifndef TIER_HOST_PARAMS_SVH
`define TIER_HOST_PARAMS_SVH

`define TH_BASE_ADDR      32'h0000_F300
`define TH_STACK_DEPTH    4
`define TH_RESP_LATENCY   0
`define TH_TIER_RESET     8'd0

// highest tier each core can host; anything above core 2 goes to core 3.
`define TH_TIER_MAX_CORE0 8'd2
`define TH_TIER_MAX_CORE1 8'd3
`define TH_TIER_MAX_CORE2 8'd6

`define TH_OFF_REQ        32'h0000_0000
`define TH_OFF_STATUS     32'h0000_0004
`define TH_OFF_ENTRY_LO   32'h0000_0008
`define TH_OFF_ENTRY_HI   32'h0000_000C
`define TH_OFF_CTRL       32'h0000_0010

`endif

/* hdl/tier_host_pkg.sv */
//==========================================================================
// Shared types of the tier host: fabric request/response and status word.
//==========================================================================
package tier_host_pkg;

  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1
  } fab_op_e;  // codes 2 and 3 are not supported.

  typedef enum logic [1:0] {
    OK           = 2'd0,
    DECODE_ERR   = 2'd1,
    ACCESS_FAULT = 2'd2
  } fab_code_e;

  typedef logic [1:0] core_id_t;
  typedef logic [7:0] tier_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    fab_op_e     op;
    logic [3:0]  id;
  } fab_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    fab_code_e   code;
    logic [3:0]  id;
  } fab_rsp_t;

  // layout of the STATUS register, msb first.
  typedef struct packed {
    logic [4:0] rsvd_hi;
    logic       err_underflow;
    logic       err_overflow;
    logic       err_invalid;
    logic [5:0] rsvd_lo;
    core_id_t   active_core;
    logic [7:0] depth;
    tier_t      active_tier;
  } th_status_t;

endpackage

/* hdl/tier_host_ctrl.sv */
//==========================================================================
// Fabric slave front end: decodes one transaction at a time, issues stack
// and entry-register strobes, keeps sticky errors and returns the response.
//==========================================================================
`timescale 1ns/1ps
`include "tier_host_params.svh"

module tier_host_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  tier_host_pkg::fab_req_t  req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output tier_host_pkg::fab_rsp_t  rsp,
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  input  tier_host_pkg::tier_t     active_tier,
  input  logic [7:0]               depth,
  input  logic                     full,
  input  logic                     empty,
  input  tier_host_pkg::core_id_t  active_core,
  input  logic [31:0]              entry_lo,
  input  logic [31:0]              entry_hi,
  output logic                     push,
  output logic                     pop,
  output tier_host_pkg::tier_t     push_tier,
  output logic                     wr_lo,
  output logic                     wr_hi,
  output logic [31:0]              wdata,
  output logic [3:0]               wstrb
);
  localparam int unsigned LAT   = `TH_RESP_LATENCY;
  localparam int unsigned CNT_W = (LAT < 2) ? 1 : $clog2(LAT + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_e;

  state_e                    state_q;
  logic [CNT_W-1:0]          wait_cnt_q;
  logic                      err_invalid_q;
  logic                      err_overflow_q;
  logic                      err_underflow_q;

  logic                      req_fire;
  logic [31:0]               off;
  logic                      is_read;
  logic                      is_write;
  logic                      hit_req;
  logic                      hit_lo;
  logic                      hit_hi;
  logic                      hit_ctrl;
  logic [7:0]                req_byte0;
  logic                      mode_up;
  logic                      mode_ret;
  logic                      not_higher;
  logic                      clr_err;
  tier_host_pkg::th_status_t status;
  logic [31:0]               rdata_d;
  tier_host_pkg::fab_code_e  code_d;

  assign req_ready = (state_q == ST_IDLE);
  assign rsp_valid = (state_q == ST_RESP);
  assign req_fire  = req_valid && req_ready;

  assign off       = req.addr - `TH_BASE_ADDR;
  assign is_read   = (req.op == tier_host_pkg::READ);
  assign is_write  = (req.op == tier_host_pkg::WRITE);
  assign hit_req   = (off == `TH_OFF_REQ);
  assign hit_lo    = (off == `TH_OFF_ENTRY_LO);
  assign hit_hi    = (off == `TH_OFF_ENTRY_HI);
  assign hit_ctrl  = (off == `TH_OFF_CTRL);
  assign req_byte0 = req.wdata[7:0];

  // bit 7 of byte 0 picks return-mode, otherwise byte 0 is the target tier.
  assign mode_up    = req_fire && is_write && hit_req && req.wstrb[0] && !req_byte0[7];
  assign mode_ret   = req_fire && is_write && hit_req && req.wstrb[0] && req_byte0[7];
  assign not_higher = (req_byte0 <= active_tier);
  assign clr_err    = req_fire && is_write && hit_ctrl && req.wstrb[0] && req.wdata[0];

  always_comb begin
    status               = '0;
    status.err_underflow = err_underflow_q;
    status.err_overflow  = err_overflow_q;
    status.err_invalid   = err_invalid_q;
    status.active_core   = active_core;
    status.depth         = depth;
    status.active_tier   = active_tier;

    rdata_d = 32'h0;
    if (is_read) begin
      case (off)
        `TH_OFF_STATUS:   rdata_d = status;
        `TH_OFF_ENTRY_LO: rdata_d = entry_lo;
        `TH_OFF_ENTRY_HI: rdata_d = entry_hi;
        default:          rdata_d = 32'h0;  // unmapped reads are harmless.
      endcase
    end

    if (!is_read && !is_write) begin
      code_d = tier_host_pkg::ACCESS_FAULT;
    end else if (is_write && !(hit_req || hit_lo || hit_hi || hit_ctrl)) begin
      code_d = tier_host_pkg::DECODE_ERR;
    end else begin
      code_d = tier_host_pkg::OK;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      wait_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_fire) begin
            state_q    <= ST_WAIT;
            wait_cnt_q <= CNT_W'(LAT);
          end
        end
        ST_WAIT: begin
          if (wait_cnt_q == '0) begin
            state_q <= ST_RESP;
          end else begin
            wait_cnt_q <= wait_cnt_q - 1'b1;
          end
        end
        ST_RESP: begin
          if (rsp_ready) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push            <= 1'b0;
      pop             <= 1'b0;
      wr_lo           <= 1'b0;
      wr_hi           <= 1'b0;
      err_invalid_q   <= 1'b0;
      err_overflow_q  <= 1'b0;
      err_underflow_q <= 1'b0;
    end else begin
      push  <= mode_up && !not_higher && !full;
      pop   <= mode_ret && !empty;
      wr_lo <= req_fire && is_write && hit_lo;
      wr_hi <= req_fire && is_write && hit_hi;
      if (clr_err) begin
        err_invalid_q   <= 1'b0;
        err_overflow_q  <= 1'b0;
        err_underflow_q <= 1'b0;
      end else begin
        // an illegal tier is reported ahead of a full stack.
        if (mode_up && not_higher)          err_invalid_q   <= 1'b1;
        if (mode_up && !not_higher && full) err_overflow_q  <= 1'b1;
        if (mode_ret && empty)              err_underflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      push_tier <= req_byte0;
      wdata     <= req.wdata;
      wstrb     <= req.wstrb;
      rsp.rdata <= rdata_d;
      rsp.code  <= code_d;
      rsp.id    <= req.id;
    end
  end

  a_push_pop_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(push && pop));

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

/* hdl/mode_stack.sv */
//==========================================================================
// Bounded tier stack. Holds the active tier and the tiers to return to.
//==========================================================================
`timescale 1ns/1ps
`include "tier_host_params.svh"

module mode_stack (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  logic                 pop,
  input  tier_host_pkg::tier_t push_tier,
  output tier_host_pkg::tier_t active_tier,
  output logic [7:0]           depth,
  output logic                 full,
  output logic                 empty
);
  localparam int unsigned DEPTH = `TH_STACK_DEPTH;
  localparam int unsigned IDX_W = (DEPTH < 2) ? 1 : $clog2(DEPTH);

  tier_host_pkg::tier_t stack_mem [DEPTH];
  tier_host_pkg::tier_t tier_q;
  logic [7:0]           depth_q;
  logic [IDX_W-1:0]     top_idx;

  assign active_tier = tier_q;
  assign depth       = depth_q;
  assign full        = (depth_q == 8'(DEPTH));
  assign empty       = (depth_q == 8'd0);
  assign top_idx     = IDX_W'(depth_q - 8'd1);  // slot of the last saved tier.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tier_q  <= `TH_TIER_RESET;
      depth_q <= 8'd0;
    end else if (push && !full) begin
      tier_q  <= push_tier;
      depth_q <= depth_q + 8'd1;
    end else if (pop && !empty) begin
      tier_q  <= stack_mem[top_idx];
      depth_q <= depth_q - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) begin
      stack_mem[IDX_W'(depth_q)] <= tier_q;  // save the tier being left.
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

/* hdl/core_select.sv */
//==========================================================================
// Maps the active tier to a hosting core, halts the others and pulses run.
//==========================================================================
`timescale 1ns/1ps
`include "tier_host_params.svh"

module core_select (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tier_host_pkg::tier_t    active_tier,
  output tier_host_pkg::core_id_t active_core,
  output logic [3:0]              core_halt_req,
  output logic [3:0]              core_run_pulse
);
  tier_host_pkg::core_id_t next_core;
  tier_host_pkg::core_id_t core_q;

  function automatic tier_host_pkg::core_id_t tier_to_core(input tier_host_pkg::tier_t t);
    if (t <= `TH_TIER_MAX_CORE0) return 2'd0;
    if (t <= `TH_TIER_MAX_CORE1) return 2'd1;
    if (t <= `TH_TIER_MAX_CORE2) return 2'd2;
    return 2'd3;
  endfunction

  assign next_core     = tier_to_core(active_tier);
  assign active_core   = core_q;
  assign core_halt_req = ~(4'b0001 << core_q);  // every core but the host.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_q         <= 2'd0;
      core_run_pulse <= 4'b0000;
    end else begin
      core_q         <= next_core;
      core_run_pulse <= (next_core != core_q) ? (4'b0001 << next_core) : 4'b0000;
    end
  end

  // a run pulse goes to one core only.
  a_run_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(core_run_pulse));

endmodule

/* hdl/entry_regs.sv */
//==========================================================================
// 64-bit entry vector held as two byte-strobed 32-bit words.
//==========================================================================
`timescale 1ns/1ps

module entry_regs (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr_lo,
  input  logic        wr_hi,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic [31:0] entry_lo,
  output logic [31:0] entry_hi
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entry_lo <= 32'h0;
      entry_hi <= 32'h0;
    end else begin
      for (int b = 0; b < 4; b++) begin
        // lanes without a strobe keep their old byte.
        if (wr_lo && wstrb[b]) begin
          entry_lo[b*8 +: 8] <= wdata[b*8 +: 8];
        end
        if (wr_hi && wstrb[b]) begin
          entry_hi[b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* hdl/tier_host_top.sv */
//==========================================================================
// Tier host top level. Fabric slave port in, core halt and run lines out.
//==========================================================================
`timescale 1ns/1ps

module tier_host_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tier_host_pkg::fab_req_t req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output tier_host_pkg::fab_rsp_t rsp,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output tier_host_pkg::tier_t    active_tier,
  output tier_host_pkg::core_id_t active_core,
  output logic [3:0]              core_halt_req,
  output logic [3:0]              core_run_pulse
);
  logic                 push;
  logic                 pop;
  tier_host_pkg::tier_t push_tier;
  logic [7:0]           depth;
  logic                 full;
  logic                 empty;
  logic                 wr_lo;
  logic                 wr_hi;
  logic [31:0]          wdata;
  logic [3:0]           wstrb;
  logic [31:0]          entry_lo;
  logic [31:0]          entry_hi;

  tier_host_ctrl i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .active_tier (active_tier),
    .depth       (depth),
    .full        (full),
    .empty       (empty),
    .active_core (active_core),
    .entry_lo    (entry_lo),
    .entry_hi    (entry_hi),
    .push        (push),
    .pop         (pop),
    .push_tier   (push_tier),
    .wr_lo       (wr_lo),
    .wr_hi       (wr_hi),
    .wdata       (wdata),
    .wstrb       (wstrb)
  );

  mode_stack i_mode_stack (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (push),
    .pop         (pop),
    .push_tier   (push_tier),
    .active_tier (active_tier),
    .depth       (depth),
    .full        (full),
    .empty       (empty)
  );

  core_select i_core_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .active_tier    (active_tier),
    .active_core    (active_core),
    .core_halt_req  (core_halt_req),
    .core_run_pulse (core_run_pulse)
  );

  entry_regs i_entry_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_lo    (wr_lo),
    .wr_hi    (wr_hi),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .entry_lo (entry_lo),
    .entry_hi (entry_hi)
  );

endmodule

/* verif/tb_tier_host.sv */
//==========================================================================
// Testbench for the tier host. Fabric accesses run against a model of the
// tier stack, sticky errors and entry registers; assertions do the checks.
//==========================================================================
`timescale 1ns/1ps
`include "tier_host_params.svh"

module tb_tier_host;
  localparam int unsigned LAT     = `TH_RESP_LATENCY;
  localparam int unsigned DEPTH   = `TH_STACK_DEPTH;
  localparam int          TIMEOUT = 64;

  logic                    clk;
  logic                    rst_n;
  tier_host_pkg::fab_req_t req;
  logic                    req_valid;
  logic                    req_ready;
  tier_host_pkg::fab_rsp_t rsp;
  logic                    rsp_valid;
  logic                    rsp_ready;
  tier_host_pkg::tier_t    active_tier;
  tier_host_pkg::core_id_t active_core;
  logic [3:0]              core_halt_req;
  logic [3:0]              core_run_pulse;

  int unsigned             assert_errors;
  int unsigned             cmp_errors;
  int unsigned             timeout_errors;
  logic [31:0]             rng_state;

  tier_host_pkg::tier_t    m_tier;  // model of the DUT state.
  tier_host_pkg::tier_t    m_stack[$];
  logic                    m_err_inv;
  logic                    m_err_ovf;
  logic                    m_err_unf;
  logic [31:0]             m_lo;
  logic [31:0]             m_hi;

  tier_host_top i_tier_host_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .rsp            (rsp),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .active_tier    (active_tier),
    .active_core    (active_core),
    .core_halt_req  (core_halt_req),
    .core_run_pulse (core_run_pulse)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  a_halt_others: assert property (@(posedge clk) disable iff (!rst_n)
    !core_halt_req[active_core] && $countones(core_halt_req) == 3)
    else begin
      assert_errors++;
      $display("FAIL %0t: halt %b with core %0d", $time, core_halt_req, active_core);
    end

  // one pulse, to the new core, in the cycle the core changes.
  a_run_on_change: assert property (@(posedge clk) disable iff (!rst_n)
    core_run_pulse == ((active_core != $past(active_core)) ? (4'b0001 << active_core) : 4'b0000))
    else begin
      assert_errors++;
      $display("FAIL %0t: run pulse %b with core %0d", $time, core_run_pulse, active_core);
    end

  a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && req_ready |=> !rsp_valid [*(LAT+1)] ##1 rsp_valid)
    else begin
      assert_errors++;
      $display("FAIL %0t: rsp_valid not %0d cycles after accept", $time, LAT + 1);
    end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      assert_errors++;
      $display("FAIL %0t: rsp changed under back-pressure", $time);
    end

  a_busy_until_hs: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && req_ready) || (!req_ready && !(rsp_valid && rsp_ready)) |=> !req_ready)
    else begin
      assert_errors++;
      $display("FAIL %0t: req_ready high before response handshake", $time);
    end

  a_ready_after_hs: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |=> !rsp_valid && req_ready)
    else begin
      assert_errors++;
      $display("FAIL %0t: port not idle after response handshake", $time);
    end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic tier_host_pkg::core_id_t host_core(input tier_host_pkg::tier_t t);
    if (t > `TH_TIER_MAX_CORE2) return 2'd3;
    if (t > `TH_TIER_MAX_CORE1) return 2'd2;
    if (t > `TH_TIER_MAX_CORE0) return 2'd1;
    return 2'd0;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        r[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] model_status();
    tier_host_pkg::th_status_t s;
    s               = '0;
    s.err_underflow = m_err_unf;
    s.err_overflow  = m_err_ovf;
    s.err_invalid   = m_err_inv;
    s.active_core   = host_core(m_tier);
    s.depth         = 8'(m_stack.size());
    s.active_tier   = m_tier;
    return s;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      cmp_errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Errors: %0d assertion, %0d compare, %0d timeout",
             assert_errors, cmp_errors, timeout_errors);
    if (assert_errors == 0 && cmp_errors == 0 && timeout_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    timeout_errors++;
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    end_run();
  endtask

  // called on a falling edge; returns on the falling edge after the handshake.
  task automatic fab_access(input tier_host_pkg::fab_op_e op, input logic [31:0] off,
                            input logic [31:0] data, input logic [3:0] strb,
                            output tier_host_pkg::fab_rsp_t got);
    int         n;
    int         stall;
    logic [3:0] id;
    logic [31:0] r;
    n = 0;
    while (!req_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!req_ready) stop_on_timeout("req_ready");
    r         = xorshift32();
    id        = r[3:0];
    req.addr  = `TH_BASE_ADDR + off;
    req.wdata = data;
    req.wstrb = strb;
    req.op    = op;
    req.id    = id;
    req_valid = 1'b1;
    @(posedge clk);
    @(negedge clk);
    req_valid = 1'b0;
    n = 0;
    while (!rsp_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rsp_valid) stop_on_timeout("rsp_valid");
    got   = rsp;
    stall = int'(r[9:8]);  // back-pressure of 0 to 3 cycles.
    repeat (stall) @(negedge clk);
    rsp_ready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    rsp_ready = 1'b0;
    check_val(got.id, id, "response id");
  endtask

  task automatic fab_write(input logic [31:0] off, input logic [31:0] data, input logic [3:0] strb);
    tier_host_pkg::fab_rsp_t  got;
    tier_host_pkg::fab_code_e exp_code;
    exp_code = tier_host_pkg::OK;
    case (off)
      `TH_OFF_REQ: begin
        if (strb[0] && data[7]) begin
          if (m_stack.size() == 0) begin
            m_err_unf = 1'b1;
          end else begin
            m_tier = m_stack.pop_back();
          end
        end else if (strb[0]) begin
          if (data[7:0] <= m_tier) begin
            m_err_inv = 1'b1;
          end else if (m_stack.size() == DEPTH) begin
            m_err_ovf = 1'b1;
          end else begin
            m_stack.push_back(m_tier);
            m_tier = data[7:0];
          end
        end
      end
      `TH_OFF_ENTRY_LO: m_lo = merge_bytes(m_lo, data, strb);
      `TH_OFF_ENTRY_HI: m_hi = merge_bytes(m_hi, data, strb);
      `TH_OFF_CTRL: begin
        if (strb[0] && data[0]) begin
          m_err_inv = 1'b0;
          m_err_ovf = 1'b0;
          m_err_unf = 1'b0;
        end
      end
      default: exp_code = tier_host_pkg::DECODE_ERR;
    endcase
    fab_access(tier_host_pkg::WRITE, off, data, strb, got);
    check_val(got.code, exp_code, "write response code");
    check_val(active_tier, m_tier, "active_tier");
    check_val(active_core, host_core(m_tier), "active_core");
  endtask

  task automatic fab_read(input logic [31:0] off);
    tier_host_pkg::fab_rsp_t got;
    logic [31:0]             exp;
    case (off)
      `TH_OFF_STATUS:   exp = model_status();
      `TH_OFF_ENTRY_LO: exp = m_lo;
      `TH_OFF_ENTRY_HI: exp = m_hi;
      default:          exp = 32'h0;
    endcase
    fab_access(tier_host_pkg::READ, off, xorshift32(), 4'hF, got);
    check_val(got.code, tier_host_pkg::OK, "read response code");
    check_val(got.rdata, exp, "read data");
  endtask

  task automatic do_bad_op(input logic [1:0] op, input logic [31:0] off, input logic [31:0] data);
    tier_host_pkg::fab_rsp_t got;
    fab_access(tier_host_pkg::fab_op_e'(op), off, data, 4'hF, got);
    check_val(got.code, tier_host_pkg::ACCESS_FAULT, "unsupported op code");
  endtask

  task automatic mode_up(input tier_host_pkg::tier_t t);
    logic [31:0] r;
    r = xorshift32();
    fab_write(`TH_OFF_REQ, {r[31:8], t}, r[3:0] | 4'b0001);
  endtask

  task automatic mode_ret();
    logic [31:0] r;
    r = xorshift32();
    fab_write(`TH_OFF_REQ, {r[31:8], 1'b1, r[6:0]}, r[3:0] | 4'b0001);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    rst_n          = 1'b0;
    req            = '0;
    req_valid      = 1'b0;
    rsp_ready      = 1'b0;
    assert_errors  = 0;
    cmp_errors     = 0;
    timeout_errors = 0;
    rng_state      = 32'd99214;
    m_tier         = `TH_TIER_RESET;
    m_err_inv      = 1'b0;
    m_err_ovf      = 1'b0;
    m_err_unf      = 1'b0;
    m_lo           = 32'h0;
    m_hi           = 32'h0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_val(req_ready, 1'b1, "req_ready after reset");
    check_val(rsp_valid, 1'b0, "rsp_valid after reset");
    check_val(core_run_pulse, 4'b0000, "core_run_pulse after reset");
    check_val(core_halt_req, 4'b1110, "core_halt_req after reset");
    check_val(active_tier, `TH_TIER_RESET, "active_tier after reset");
    check_val(active_core, 2'd0, "active_core after reset");
    fab_read(`TH_OFF_STATUS);

    mode_up(8'd1);  // same core, no run pulse.
    mode_up(8'd3);
    fab_read(`TH_OFF_STATUS);
    mode_up(8'd2);
    mode_up(8'd3);
    fab_write(`TH_OFF_REQ, 32'h0000_0009, 4'b1110);  // no byte 0, no effect.
    fab_read(`TH_OFF_STATUS);
    fab_write(`TH_OFF_CTRL, 32'h1, 4'b0001);
    while (m_stack.size() > 0) begin
      mode_ret();
    end
    fab_read(`TH_OFF_STATUS);

    for (int i = 0; i < DEPTH; i++) begin
      r = xorshift32();
      mode_up(m_tier + 8'd2 + 8'(r[0]));
      fab_read(`TH_OFF_STATUS);
    end
    mode_up(m_tier + 8'd1);
    fab_read(`TH_OFF_STATUS);
    for (int i = 0; i < DEPTH; i++) begin
      mode_ret();
      fab_read(`TH_OFF_STATUS);
    end
    mode_ret();
    fab_read(`TH_OFF_STATUS);
    fab_write(`TH_OFF_CTRL, 32'h1, 4'b0001);
    fab_read(`TH_OFF_STATUS);

    for (int i = 0; i < 8; i++) begin
      r = xorshift32();
      d = xorshift32();
      fab_write(r[0] ? `TH_OFF_ENTRY_HI : `TH_OFF_ENTRY_LO, d, r[7:4]);
      fab_read(`TH_OFF_ENTRY_LO);
      fab_read(`TH_OFF_ENTRY_HI);
    end

    fab_write(32'h14, xorshift32(), 4'hF);
    fab_write(`TH_OFF_STATUS, xorshift32(), 4'hF);
    fab_write(32'h100, xorshift32(), 4'hF);
    fab_read(32'h14);
    fab_read(`TH_OFF_CTRL);
    fab_read(`TH_OFF_REQ);
    mode_ret();  // leaves err_underflow set for the fault checks.
    do_bad_op(2'd2, `TH_OFF_REQ, 32'h0000_0040);
    do_bad_op(2'd3, `TH_OFF_CTRL, 32'h1);
    do_bad_op(2'd2, `TH_OFF_ENTRY_LO, xorshift32());
    fab_read(`TH_OFF_STATUS);
    fab_read(`TH_OFF_ENTRY_LO);
    end_run();
  end

endmodule

/* tier_host.f */
+incdir+hdl
hdl/tier_host_pkg.sv
hdl/tier_host_ctrl.sv
hdl/mode_stack.sv
hdl/core_select.sv
hdl/entry_regs.sv
hdl/tier_host_top.sv
verif/tb_tier_host.sv
